/* logic/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	////////////////////////////////////////
	// field types

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_NOR = 4'd5,
		ALU_SLT = 4'd6,
		ALU_SLL = 4'd7,
		ALU_SRL = 4'd8,
		ALU_SRA = 4'd9,
		ALU_LUI = 4'd10
	} alu_op_e;

	// operand source picked by the forwarding unit
	typedef enum logic [1:0] {
		FWD_REG = 2'd0, // register file read
		FWD_MEM = 2'd1, // one instruction back
		FWD_WB  = 2'd2  // two instructions back
	} fwd_sel_e;

	////////////////////////////////////////
	// instruction word, r and i views

	typedef struct packed {
		opcode_t op;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		reg_idx_t shamt;
		funct_t funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_t op;
		reg_idx_t rs;
		reg_idx_t rt;
		logic [15:0] imm16;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_u;

	////////////////////////////////////////
	// opcodes

	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_BEQ   = 6'h04;
	localparam opcode_t OP_BNE   = 6'h05;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_SLTI  = 6'h0a;
	localparam opcode_t OP_ANDI  = 6'h0c;
	localparam opcode_t OP_ORI   = 6'h0d;
	localparam opcode_t OP_XORI  = 6'h0e;
	localparam opcode_t OP_LUI   = 6'h0f;

	// funct codes, r-type only
	localparam funct_t FN_SLL = 6'h00;
	localparam funct_t FN_SRL = 6'h02;
	localparam funct_t FN_SRA = 6'h03;
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR  = 6'h25;
	localparam funct_t FN_XOR = 6'h26;
	localparam funct_t FN_NOR = 6'h27;
	localparam funct_t FN_SLT = 6'h2a;

endpackage

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
	input wire mips_pkg::word_t a,
	input wire mips_pkg::word_t b,
	input wire mips_pkg::alu_op_e op,
	output mips_pkg::word_t result,
	output logic zero,
	output logic neg
);
	import mips_pkg::*;

	////////////////////////////////////////
	// operation select

	always_comb
	begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_NOR: result = ~(a | b);
			ALU_SLT: result = {31'd0, $signed(a) < $signed(b)}; // signed compare
			// shifts take the amount from a, data from b
			ALU_SLL: result = b << a[4:0];
			ALU_SRL: result = b >> a[4:0];
			ALU_SRA: result = $signed(b) >>> a[4:0];
			ALU_LUI: result = b << 16; // immediate into the upper half
			default: result = '0;
		endcase
	end

	// flags
	assign zero = result == '0;
	assign neg = result[31];

endmodule

`default_nettype wire

/* logic/forwarding_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module forwarding_unit (
	input wire mips_pkg::reg_idx_t rs,
	input wire mips_pkg::reg_idx_t rt,
	input wire mem_write,
	input wire wb_write,
	input wire mips_pkg::reg_idx_t mem_dest,
	input wire mips_pkg::reg_idx_t wb_dest,
	input wire mips_pkg::word_t reg1,
	input wire mips_pkg::word_t reg2,
	input wire mips_pkg::word_t mem_data,
	input wire mips_pkg::word_t wb_data,
	output mips_pkg::word_t op1,
	output mips_pkg::word_t op2
);
	import mips_pkg::*;

	fwd_sel_e sel1;
	fwd_sel_e sel2;

	// nearest producer wins
	function automatic fwd_sel_e pick(input reg_idx_t src);
		if (mem_write && mem_dest == src)
			return FWD_MEM;
		else if (wb_write && wb_dest == src)
			return FWD_WB;
		else
			return FWD_REG;
	endfunction

	function automatic word_t select(input fwd_sel_e sel, input word_t reg_val);
		case (sel)
			FWD_MEM: return mem_data;
			FWD_WB: return wb_data;
			default: return reg_val;
		endcase
	endfunction

	always_comb
	begin
		sel1 = pick(rs);
		sel2 = pick(rt);
		op1 = select(sel1, reg1); // alu a side
		op2 = select(sel2, reg2); // alu b side, also branch compare
	end

	// a read of r0 must stay on the register file path
	always_comb
	begin
		a_r0_not_forwarded: assert (!(sel1 != FWD_REG && rs == '0) && !(sel2 != FWD_REG && rt == '0))
			else $error("forwarding_unit: r0 read picked up a forwarded word");
	end

endmodule

`default_nettype wire

/* logic/register_file.sv */
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input wire clk,
	input wire rst,
	input wire mips_pkg::reg_idx_t rd_addr1,
	input wire mips_pkg::reg_idx_t rd_addr2,
	output mips_pkg::word_t rd_data1,
	output mips_pkg::word_t rd_data2,
	input wire wr_en,
	input wire mips_pkg::reg_idx_t wr_addr,
	input wire mips_pkg::word_t wr_data
);
	import mips_pkg::*;

	word_t regs [32];

	// r0 reads zero, same-cycle write passes straight through
	function automatic word_t read_port(input reg_idx_t addr);
		if (addr == '0)
			return '0;
		else if (wr_en && wr_addr == addr)
			return wr_data;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_en && wr_addr != '0) // r0 never written
			regs[wr_addr] <= wr_data;
	end

	assign rd_data1 = read_port(rd_addr1);
	assign rd_data2 = read_port(rd_addr2);

endmodule

`default_nettype wire

/* logic/instr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
	input wire clk,
	input wire rst,
	input wire instr_valid,
	input wire mips_pkg::instr_u instr,
	input wire mips_pkg::word_t pc,
	output mips_pkg::reg_idx_t rd_addr1,
	output mips_pkg::reg_idx_t rd_addr2,
	input wire mips_pkg::word_t rd_data1,
	input wire mips_pkg::word_t rd_data2,
	output logic id_valid,
	output mips_pkg::word_t id_reg1,
	output mips_pkg::word_t id_reg2,
	output mips_pkg::word_t id_sign_ext,
	output mips_pkg::word_t id_pc,
	output mips_pkg::reg_idx_t id_rs,
	output mips_pkg::reg_idx_t id_rt,
	output mips_pkg::reg_idx_t id_rd,
	output mips_pkg::reg_idx_t id_shamt,
	output mips_pkg::alu_op_e id_alu_op,
	output logic id_use_shamt,
	output logic id_use_imm,
	output logic id_dest_rd,
	output logic id_reg_write,
	output logic id_is_branch,
	output logic id_branch_ne
);
	import mips_pkg::*;

	alu_op_e alu_op;
	logic rtype;
	logic use_shamt;
	logic use_imm;
	logic reg_write;
	logic is_branch;
	logic zero_ext; // andi/ori/xori
	logic known;
	word_t imm_ext;

	////////////////////////////////////////
	// opcode / funct decode

	always_comb
	begin
		rtype = instr.r.op == OP_RTYPE;
		alu_op = ALU_ADD;
		use_shamt = 1'b0;
		use_imm = 1'b1; // i-type default
		reg_write = 1'b1;
		is_branch = 1'b0;
		zero_ext = 1'b0;
		known = 1'b1;
		case (instr.r.op)
			OP_RTYPE:
			begin
				use_imm = 1'b0;
				use_shamt = instr.r.funct inside {FN_SLL, FN_SRL, FN_SRA};
				case (instr.r.funct)
					FN_ADD: alu_op = ALU_ADD;
					FN_SUB: alu_op = ALU_SUB;
					FN_AND: alu_op = ALU_AND;
					FN_OR: alu_op = ALU_OR;
					FN_XOR: alu_op = ALU_XOR;
					FN_NOR: alu_op = ALU_NOR;
					FN_SLT: alu_op = ALU_SLT;
					FN_SLL: alu_op = ALU_SLL;
					FN_SRL: alu_op = ALU_SRL;
					FN_SRA: alu_op = ALU_SRA;
					default:
					begin
						known = 1'b0;
						reg_write = 1'b0; // unknown funct retires as a no-op
					end
				endcase
			end
			OP_ADDI: alu_op = ALU_ADD;
			OP_SLTI: alu_op = ALU_SLT;
			OP_ANDI:
			begin
				alu_op = ALU_AND;
				zero_ext = 1'b1;
			end
			OP_ORI:
			begin
				alu_op = ALU_OR;
				zero_ext = 1'b1;
			end
			OP_XORI:
			begin
				alu_op = ALU_XOR;
				zero_ext = 1'b1;
			end
			OP_LUI: alu_op = ALU_LUI;
			OP_BEQ, OP_BNE:
			begin
				alu_op = ALU_SUB; // rs - rt, zero flag decides
				use_imm = 1'b0;
				reg_write = 1'b0;
				is_branch = 1'b1;
			end
			default:
			begin
				known = 1'b0;
				reg_write = 1'b0;
			end
		endcase
		imm_ext = zero_ext ? {16'h0000, instr.i.imm16} : {{16{instr.i.imm16[15]}}, instr.i.imm16};
	end

	////////////////////////////////////////
	// id/ex latch

	always_ff @(posedge clk)
	begin
		if (rst)
			id_valid <= 1'b0;
		else
			id_valid <= instr_valid; // bubble when no strobe
	end

	always_ff @(posedge clk)
	begin
		if (instr_valid)
		begin
			id_pc <= pc;
			id_sign_ext <= imm_ext;
			id_rs <= instr.r.rs;
			id_rt <= instr.r.rt;
			id_rd <= instr.r.rd;
			id_shamt <= instr.r.shamt;
			id_alu_op <= alu_op;
			id_use_shamt <= use_shamt;
			id_use_imm <= use_imm;
			id_dest_rd <= rtype; // r-type writes rd, i-type writes rt
			id_reg_write <= reg_write;
			id_is_branch <= is_branch;
			id_branch_ne <= instr.i.op == OP_BNE;
		end
	end

	// register read on the latched indices, lands in the execute cycle
	// so the write-through in the register file covers distance 3
	assign rd_addr1 = id_rs;
	assign rd_addr2 = id_rt;
	assign id_reg1 = rd_data1;
	assign id_reg2 = rd_data2;

	a_known_op: assert property (@(posedge clk) disable iff (rst) instr_valid |-> known)
		else $error("instr_decode: unknown op %h funct %h", instr.r.op, instr.r.funct);

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
	input wire clk,
	input wire rst,
	input wire id_valid,
	input wire mips_pkg::word_t id_reg1,
	input wire mips_pkg::word_t id_reg2,
	input wire mips_pkg::word_t id_sign_ext,
	input wire mips_pkg::word_t id_pc,
	input wire mips_pkg::reg_idx_t id_rs,
	input wire mips_pkg::reg_idx_t id_rt,
	input wire mips_pkg::reg_idx_t id_rd,
	input wire mips_pkg::reg_idx_t id_shamt,
	input wire mips_pkg::alu_op_e id_alu_op,
	input wire id_use_shamt,
	input wire id_use_imm,
	input wire id_dest_rd,
	input wire id_reg_write,
	input wire id_is_branch,
	input wire id_branch_ne,
	input wire mips_pkg::word_t mem_fwd_data,
	input wire mips_pkg::reg_idx_t mem_fwd_dest,
	input wire mem_fwd_write,
	input wire mips_pkg::word_t wb_fwd_data,
	input wire mips_pkg::reg_idx_t wb_fwd_dest,
	input wire wb_fwd_write,
	output logic ex_valid,
	output mips_pkg::word_t ex_alu,
	output mips_pkg::reg_idx_t ex_dest,
	output logic ex_write,
	output mips_pkg::word_t ex_target,
	output logic ex_zero,
	output logic ex_neg,
	output logic ex_taken
);
	import mips_pkg::*;

	word_t op1;
	word_t op2;
	word_t alu_a;
	word_t alu_b;
	word_t alu_y;
	logic alu_zero;
	logic alu_neg;
	reg_idx_t dest;

	forwarding_unit u_fwd (
		.rs(id_rs),
		.rt(id_rt),
		.mem_write(mem_fwd_write),
		.wb_write(wb_fwd_write),
		.mem_dest(mem_fwd_dest),
		.wb_dest(wb_fwd_dest),
		.reg1(id_reg1),
		.reg2(id_reg2),
		.mem_data(mem_fwd_data),
		.wb_data(wb_fwd_data),
		.op1(op1),
		.op2(op2)
	);

	assign alu_a = id_use_shamt ? {27'd0, id_shamt} : op1; // shamt as the amount
	assign alu_b = id_use_imm ? id_sign_ext : op2;

	alu u_alu (
		.a(alu_a),
		.b(alu_b),
		.op(id_alu_op),
		.result(alu_y),
		.zero(alu_zero),
		.neg(alu_neg)
	);

	assign dest = id_dest_rd ? id_rd : id_rt;

	////////////////////////////////////////
	// ex/mem latch

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ex_valid <= 1'b0;
			ex_write <= 1'b0;
			ex_taken <= 1'b0;
		end
		else
		begin
			ex_valid <= id_valid;
			ex_write <= id_valid && id_reg_write && dest != '0; // r0 never forwarded
			ex_taken <= id_valid && id_is_branch && (alu_zero != id_branch_ne);
		end
	end

	always_ff @(posedge clk)
	begin
		ex_alu <= alu_y;
		ex_dest <= dest;
		ex_zero <= alu_zero;
		ex_neg <= alu_neg;
		// low half re-extended, andi/ori/xori latch a zero-extended immediate
		ex_target <= id_pc + {{16{id_sign_ext[15]}}, id_sign_ext[15:0]};
	end

endmodule

`default_nettype wire

/* logic/mem_wb_pipe.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_wb_pipe (
	input wire clk,
	input wire rst,
	input wire ex_valid,
	input wire mips_pkg::word_t ex_alu,
	input wire mips_pkg::reg_idx_t ex_dest,
	input wire ex_write,
	input wire mips_pkg::word_t ex_target,
	input wire ex_zero,
	input wire ex_neg,
	input wire ex_taken,
	output mips_pkg::word_t mem_fwd_data,
	output mips_pkg::reg_idx_t mem_fwd_dest,
	output logic mem_fwd_write,
	output logic wb_valid,
	output logic wb_write,
	output mips_pkg::reg_idx_t wb_dest,
	output mips_pkg::word_t wb_data,
	output mips_pkg::word_t wb_target,
	output logic wb_zero,
	output logic wb_neg,
	output logic wb_taken
);
	import mips_pkg::*;

	// rest of the mem latch, the forwarding outputs hold the other half
	logic mem_valid;
	logic mem_zero;
	logic mem_neg;
	logic mem_taken;
	word_t mem_target;

	// control, flags only move while their stage is valid
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mem_valid <= 1'b0;
			mem_fwd_write <= 1'b0;
			mem_taken <= 1'b0;
			wb_valid <= 1'b0;
			wb_write <= 1'b0;
			wb_taken <= 1'b0;
		end
		else
		begin
			mem_valid <= ex_valid;
			mem_fwd_write <= ex_valid && ex_write;
			mem_taken <= ex_valid && ex_taken;
			wb_valid <= mem_valid;
			wb_write <= mem_valid && mem_fwd_write;
			wb_taken <= mem_valid && mem_taken;
		end
	end

	// payload, no data memory so just carried
	always_ff @(posedge clk)
	begin
		mem_fwd_data <= ex_alu;
		mem_fwd_dest <= ex_dest;
		mem_target <= ex_target;
		mem_zero <= ex_zero;
		mem_neg <= ex_neg;
		wb_data <= mem_fwd_data;
		wb_dest <= mem_fwd_dest;
		wb_target <= mem_target;
		wb_zero <= mem_zero;
		wb_neg <= mem_neg;
	end

	a_no_r0_write: assert property (@(posedge clk) disable iff (rst) wb_write |-> wb_dest != '0)
		else $error("mem_wb_pipe: write to r0 reached writeback");

endmodule

`default_nettype wire

/* logic/ex_pipe_top.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_pipe_top (
	input wire clk,
	input wire rst,
	input wire instr_valid,
	input wire mips_pkg::instr_u instr,
	input wire mips_pkg::word_t pc,
	output logic wb_valid,
	output logic wb_write,
	output mips_pkg::reg_idx_t wb_dest,
	output mips_pkg::word_t wb_data,
	output mips_pkg::word_t wb_target,
	output logic wb_zero,
	output logic wb_neg,
	output logic wb_taken
);
	import mips_pkg::*;

	reg_idx_t rd_addr1, rd_addr2;
	word_t rd_data1, rd_data2;

	// id/ex latch
	logic id_valid, id_use_shamt, id_use_imm, id_dest_rd;
	logic id_reg_write, id_is_branch, id_branch_ne;
	word_t id_reg1, id_reg2, id_sign_ext, id_pc;
	reg_idx_t id_rs, id_rt, id_rd, id_shamt;
	alu_op_e id_alu_op;

	// ex/mem latch and mem/wb forwarding source
	logic ex_valid, ex_write, ex_zero, ex_neg, ex_taken;
	word_t ex_alu, ex_target;
	reg_idx_t ex_dest;
	word_t mem_fwd_data;
	reg_idx_t mem_fwd_dest;
	logic mem_fwd_write;

	instr_decode u_decode (.*);

	// writeback port doubles as the write-through for distance 3
	register_file u_rf (.*, .wr_en(wb_write), .wr_addr(wb_dest), .wr_data(wb_data));

	// distance 1 from the ex/mem latch, distance 2 from the mem latch
	execute_stage u_exec (
		.*,
		.mem_fwd_data(ex_alu),
		.mem_fwd_dest(ex_dest),
		.mem_fwd_write(ex_write),
		.wb_fwd_data(mem_fwd_data),
		.wb_fwd_dest(mem_fwd_dest),
		.wb_fwd_write(mem_fwd_write)
	);

	mem_wb_pipe u_memwb (.*);

endmodule

`default_nettype wire

/* tests/ex_pipe_model.svh */
`ifndef EX_PIPE_MODEL_SVH
`define EX_PIPE_MODEL_SVH

// one retired instruction as the writeback ports should show it
typedef struct packed {
	logic write;
	reg_idx_t dest;
	word_t data;
	word_t target;
	logic zero;
	logic neg;
	logic taken;
} expect_t;

word_t model_regs [32]; // architectural state in program order, r0 stays zero
logic [31:0] lfsr = 32'h9996f9c6;

////////////////////////////////////////
// random source

// fibonacci, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] random_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		lfsr = lfsr_step(lfsr); // one step per bit
		v = {v[30:0], lfsr[0]};
	end
	return v;
endfunction

////////////////////////////////////////
// encoders

function automatic instr_u r_word(input funct_t fn, input reg_idx_t rd, input reg_idx_t rs,
		input reg_idx_t rt, input reg_idx_t shamt);
	instr_u w;
	w.r.op = OP_RTYPE;
	w.r.rs = rs;
	w.r.rt = rt;
	w.r.rd = rd;
	w.r.shamt = shamt;
	w.r.funct = fn;
	return w;
endfunction

function automatic instr_u i_word(input opcode_t op, input reg_idx_t rt, input reg_idx_t rs,
		input logic [15:0] imm);
	instr_u w;
	w.i.op = op;
	w.i.rs = rs;
	w.i.rt = rt;
	w.i.imm16 = imm;
	return w;
endfunction

////////////////////////////////////////
// reference model

// two's complement order from the sign bits first
function automatic logic signed_less(input word_t x, input word_t y);
	return (x[31] != y[31]) ? x[31] : (x < y);
endfunction

function automatic word_t shift_arith(input word_t x, input reg_idx_t sh);
	return (x >> sh) | (x[31] ? ~(32'hffff_ffff >> sh) : 32'h0000_0000); // refill with sign
endfunction

function automatic expect_t predict(input instr_u w, input word_t at);
	expect_t e;
	word_t a;
	word_t b;
	word_t imm_s;
	word_t imm_z;
	word_t y;
	a = model_regs[w.r.rs];
	b = model_regs[w.r.rt];
	imm_s = {{16{w.i.imm16[15]}}, w.i.imm16};
	imm_z = {16'h0000, w.i.imm16};
	y = '0;
	e.write = 1'b1;
	e.taken = 1'b0;
	e.dest = (w.r.op == OP_RTYPE) ? w.r.rd : w.i.rt; // rd for r-type, rt otherwise
	case (w.r.op)
		OP_RTYPE:
		begin
			case (w.r.funct)
				FN_ADD: y = a + b;
				FN_SUB: y = a - b;
				FN_AND: y = a & b;
				FN_OR: y = a | b;
				FN_XOR: y = a ^ b;
				FN_NOR: y = ~(a | b);
				FN_SLT: y = {31'd0, signed_less(a, b)};
				FN_SLL: y = b << w.r.shamt;
				FN_SRL: y = b >> w.r.shamt;
				FN_SRA: y = shift_arith(b, w.r.shamt);
				default: e.write = 1'b0;
			endcase
		end
		OP_ADDI: y = a + imm_s;
		OP_SLTI: y = {31'd0, signed_less(a, imm_s)};
		OP_ANDI: y = a & imm_z;
		OP_ORI: y = a | imm_z;
		OP_XORI: y = a ^ imm_z;
		OP_LUI: y = {w.i.imm16, 16'h0000};
		OP_BEQ, OP_BNE:
		begin
			y = a - b; // compare result shows up as data
			e.write = 1'b0;
			e.taken = (a == b) == (w.i.op == OP_BEQ);
		end
		default: e.write = 1'b0;
	endcase
	if (e.dest == 5'd0)
		e.write = 1'b0; // r0 never written
	e.data = y;
	e.zero = y == 32'd0;
	e.neg = y[31];
	e.target = at + imm_s;
	if (e.write)
		model_regs[e.dest] = y;
	return e;
endfunction

`endif

/* tests/ex_pipe_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_pipe_tb;
	import mips_pkg::*;

	`include "ex_pipe_model.svh"

	localparam int WB_TIMEOUT = 12; // cycles without wb_valid while work is outstanding
	localparam int DRAIN_TIMEOUT = 40;

	logic clk;
	logic rst;
	logic instr_valid;
	instr_u instr;
	word_t pc;
	logic wb_valid;
	logic wb_write;
	reg_idx_t wb_dest;
	word_t wb_data;
	word_t wb_target;
	logic wb_zero;
	logic wb_neg;
	logic wb_taken;

	expect_t exp_q [$]; // in issue order
	word_t pc_next;
	int checked;
	int errors;
	int test_num;
	int test_checked;
	int test_errors;
	string test_name;
	logic hung;

	ex_pipe_top dut0 (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.instr(instr),
		.pc(pc),
		.wb_valid(wb_valid),
		.wb_write(wb_write),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.wb_target(wb_target),
		.wb_zero(wb_zero),
		.wb_neg(wb_neg),
		.wb_taken(wb_taken)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////
	// stimulus helpers

	function automatic reg_idx_t src_reg(); // r1..r15
		reg_idx_t r;
		r = reg_idx_t'(random_bits(4));
		if (r == 5'd0)
			r = 5'd1;
		return r;
	endfunction

	function automatic reg_idx_t dst_reg(); // r16..r31
		return 5'd16 + reg_idx_t'(random_bits(4));
	endfunction

	function automatic funct_t alu_funct();
		funct_t fn;
		case (random_bits(3))
			0: fn = FN_ADD;
			1: fn = FN_AND;
			2: fn = FN_OR;
			3: fn = FN_XOR;
			4: fn = FN_NOR;
			5: fn = FN_SLT;
			default: fn = FN_SUB;
		endcase
		return fn;
	endfunction

	function automatic opcode_t imm_opcode();
		opcode_t op;
		case (random_bits(3))
			0: op = OP_ADDI;
			1: op = OP_SLTI;
			2: op = OP_ANDI;
			3: op = OP_ORI;
			4: op = OP_XORI;
			default: op = OP_LUI; // lui a bit more often
		endcase
		return op;
	endfunction

	// any kept instruction on r0..r7, so dependencies come often
	function automatic instr_u any_instr();
		instr_u w;
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t sh;
		logic [15:0] imm;
		int k;
		rd = reg_idx_t'(random_bits(3));
		rs = reg_idx_t'(random_bits(3));
		rt = reg_idx_t'(random_bits(3));
		sh = reg_idx_t'(random_bits(5));
		imm = 16'(random_bits(16));
		k = int'(random_bits(5) % 32'd18);
		case (k)
			0: w = r_word(FN_ADD, rd, rs, rt, 5'd0);
			1: w = r_word(FN_SUB, rd, rs, rt, 5'd0);
			2: w = r_word(FN_AND, rd, rs, rt, 5'd0);
			3: w = r_word(FN_OR, rd, rs, rt, 5'd0);
			4: w = r_word(FN_XOR, rd, rs, rt, 5'd0);
			5: w = r_word(FN_NOR, rd, rs, rt, 5'd0);
			6: w = r_word(FN_SLT, rd, rs, rt, 5'd0);
			7: w = r_word(FN_SLL, rd, rs, rt, sh);
			8: w = r_word(FN_SRL, rd, rs, rt, sh);
			9: w = r_word(FN_SRA, rd, rs, rt, sh);
			10: w = i_word(OP_ADDI, rd, rs, imm);
			11: w = i_word(OP_SLTI, rd, rs, imm);
			12: w = i_word(OP_ANDI, rd, rs, imm);
			13: w = i_word(OP_ORI, rd, rs, imm);
			14: w = i_word(OP_XORI, rd, rs, imm);
			15: w = i_word(OP_LUI, rd, rs, imm);
			16: w = i_word(OP_BEQ, rt, rs, imm);
			default: w = i_word(OP_BNE, rt, rs, imm);
		endcase
		return w;
	endfunction

	// one instruction on the next falling edge, expectation queued at once
	task automatic issue(input instr_u w);
		@(negedge clk);
		instr_valid = 1'b1;
		instr = w;
		pc = pc_next;
		exp_q.push_back(predict(w, pc_next));
		pc_next = pc_next + 32'd4;
	endtask

	task automatic gap(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(negedge clk);
			instr_valid = 1'b0;
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		@(negedge clk);
		instr_valid = 1'b0;
		while (exp_q.size() > 0 && waited < DRAIN_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() > 0)
			hung = 1'b1;
	endtask

	task automatic start_test(input string name);
		test_num++;
		test_name = name;
		test_checked = checked;
		test_errors = errors;
	endtask

	task automatic end_test();
		drain();
		$display("test %0d %s: %0d results, %0d errors", test_num, test_name,
			checked - test_checked, errors - test_errors);
	endtask

	////////////////////////////////////////
	// checking

	task automatic check_field(input string name, input word_t got, input word_t want);
		assert (got === want)
		else
		begin
			$display("FAILED %s: got %0h expected %0h", name, got, want);
			errors++;
		end
	endtask

	task automatic check_result();
		expect_t e;
		assert (exp_q.size() > 0)
		else
		begin
			$display("wb_valid arrived with no instruction outstanding");
			errors++;
		end
		if (exp_q.size() > 0)
		begin
			e = exp_q.pop_front();
			checked++;
			check_field("wb_write", word_t'(wb_write), word_t'(e.write));
			check_field("wb_dest", word_t'(wb_dest), word_t'(e.dest));
			check_field("wb_data", wb_data, e.data);
			check_field("wb_target", wb_target, e.target);
			check_field("wb_zero", word_t'(wb_zero), word_t'(e.zero));
			check_field("wb_neg", word_t'(wb_neg), word_t'(e.neg));
			check_field("wb_taken", word_t'(wb_taken), word_t'(e.taken));
		end
	endtask

	// outputs sampled mid-cycle, away from the rising edge
	initial
	begin : compare
		int idle;
		idle = 0;
		while (idle <= WB_TIMEOUT)
		begin
			@(negedge clk);
			if (rst || (!wb_valid && exp_q.size() == 0))
				idle = 0;
			else if (!wb_valid)
				idle++; // result still in flight
			else
			begin
				idle = 0;
				check_result();
			end
		end
		$display("no wb_valid within %0d cycles while results were outstanding", WB_TIMEOUT);
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////
	// tests

	task automatic load_and_rtype();
		start_test("load and r-type");
		issue(i_word(OP_LUI, 5'd1, 5'd0, 16'hf00d)); // r1 negative on purpose
		issue(i_word(OP_ORI, 5'd1, 5'd1, 16'h1235));
		for (int r = 2; r < 16; r++)
		begin
			issue(i_word(OP_LUI, reg_idx_t'(r), 5'd0, 16'(random_bits(16))));
			issue(i_word(OP_ORI, reg_idx_t'(r), reg_idx_t'(r), 16'(random_bits(16))));
		end
		issue(r_word(FN_SUB, 5'd16, 5'd3, 5'd3, 5'd0)); // zero flag
		issue(r_word(FN_SLT, 5'd17, 5'd1, 5'd2, 5'd0));
		for (int n = 0; n < 40; n++)
			issue(r_word(alu_funct(), dst_reg(), src_reg(), src_reg(), 5'd0));
		end_test();
	endtask

	task automatic immediates();
		start_test("i-type");
		issue(i_word(OP_ADDI, 5'd20, 5'd1, 16'h8000)); // sign bit set
		issue(i_word(OP_SLTI, 5'd21, 5'd2, 16'hffff));
		issue(i_word(OP_SLTI, 5'd22, 5'd1, 16'h0000)); // r1 below zero
		issue(i_word(OP_ANDI, 5'd23, 5'd3, 16'hffff)); // upper half cleared
		issue(i_word(OP_ORI, 5'd24, 5'd4, 16'h8000));
		issue(i_word(OP_XORI, 5'd25, 5'd5, 16'hffff));
		issue(i_word(OP_LUI, 5'd26, 5'd6, 16'h8001));
		for (int n = 0; n < 30; n++)
			issue(i_word(imm_opcode(), dst_reg(), src_reg(), 16'(random_bits(16))));
		end_test();
	endtask

	task automatic shifts();
		funct_t fn;
		start_test("shifts");
		for (int f = 0; f < 3; f++)
		begin
			fn = (f == 0) ? FN_SLL : (f == 1) ? FN_SRL : FN_SRA;
			issue(r_word(fn, dst_reg(), src_reg(), 5'd1, 5'd0));
			issue(r_word(fn, dst_reg(), src_reg(), 5'd1, 5'd31));
			issue(r_word(fn, dst_reg(), src_reg(), src_reg(), 5'd0));
			issue(r_word(fn, dst_reg(), src_reg(), src_reg(), 5'd31));
			for (int n = 0; n < 6; n++)
				issue(r_word(fn, dst_reg(), src_reg(), src_reg(), reg_idx_t'(random_bits(5))));
		end
		end_test();
	endtask

	task automatic forwarding();
		start_test("forwarding");
		// distance 1, rs side then rt side
		issue(i_word(OP_ADDI, 5'd20, 5'd1, 16'd5));
		issue(r_word(FN_ADD, 5'd21, 5'd20, 5'd2, 5'd0));
		issue(r_word(FN_SUB, 5'd22, 5'd3, 5'd21, 5'd0));
		// distance 2
		issue(i_word(OP_XORI, 5'd23, 5'd4, 16'h5a5a));
		issue(r_word(FN_OR, 5'd24, 5'd5, 5'd6, 5'd0));
		issue(r_word(FN_AND, 5'd25, 5'd23, 5'd23, 5'd0));
		// distance 3, through the register file write-through
		issue(i_word(OP_ORI, 5'd26, 5'd7, 16'h00ff));
		issue(r_word(FN_NOR, 5'd27, 5'd8, 5'd9, 5'd0));
		issue(r_word(FN_XOR, 5'd28, 5'd10, 5'd11, 5'd0));
		issue(r_word(FN_ADD, 5'd29, 5'd26, 5'd1, 5'd0));
		// r30 live at distances 1, 2 and 3, nearest wins
		issue(i_word(OP_ADDI, 5'd30, 5'd1, 16'd1));
		issue(i_word(OP_ADDI, 5'd30, 5'd30, 16'd2));
		issue(i_word(OP_ADDI, 5'd30, 5'd30, 16'd3));
		issue(r_word(FN_ADD, 5'd31, 5'd30, 5'd30, 5'd0));
		issue(r_word(FN_SRA, 5'd16, 5'd0, 5'd31, 5'd4)); // shift data forwarded
		gap(2);
		for (int n = 0; n < 300; n++)
		begin
			issue(any_instr());
			if (random_bits(2) == 0)
				gap(1 + int'(random_bits(2)));
		end
		end_test();
	endtask

	task automatic branches();
		opcode_t op;
		reg_idx_t rs;
		reg_idx_t rt;
		start_test("branches");
		issue(i_word(OP_ADDI, 5'd16, 5'd2, 16'd0)); // copy, compared right away
		issue(i_word(OP_BEQ, 5'd2, 5'd16, 16'hfff0));
		issue(i_word(OP_BNE, 5'd2, 5'd16, 16'h0010));
		issue(i_word(OP_BNE, 5'd3, 5'd16, 16'h7fff));
		for (int n = 0; n < 16; n++)
		begin
			pc_next = random_bits(32) & 32'hffff_fffc;
			op = random_bits(1) ? OP_BEQ : OP_BNE;
			rs = src_reg();
			rt = random_bits(1) ? rs : src_reg();
			issue(i_word(op, rt, rs, 16'(random_bits(16))));
			// both operands read back, unchanged
			issue(r_word(FN_OR, dst_reg(), rs, 5'd0, 5'd0));
			issue(r_word(FN_OR, dst_reg(), rt, 5'd0, 5'd0));
		end
		end_test();
	endtask

	task automatic zero_register();
		start_test("r0");
		issue(i_word(OP_ADDI, 5'd0, 5'd3, 16'd99));
		issue(r_word(FN_ADD, 5'd16, 5'd0, 5'd0, 5'd0)); // distance 1
		issue(r_word(FN_OR, 5'd17, 5'd4, 5'd0, 5'd0)); // distance 2
		issue(r_word(FN_SUB, 5'd18, 5'd0, 5'd4, 5'd0)); // distance 3
		issue(r_word(FN_ADD, 5'd0, 5'd1, 5'd2, 5'd0));
		issue(i_word(OP_LUI, 5'd0, 5'd0, 16'hdead));
		issue(r_word(FN_XOR, 5'd19, 5'd0, 5'd5, 5'd0));
		issue(i_word(OP_ORI, 5'd20, 5'd0, 16'h0000)); // zero flag set
		gap(4);
		issue(r_word(FN_NOR, 5'd21, 5'd0, 5'd0, 5'd0)); // plain register read
		end_test();
	endtask

	////////////////////////////////////////
	// main sequence

	initial
	begin
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		pc_next = 32'h0040_0004;
		checked = 0;
		errors = 0;
		test_num = 0;
		hung = 1'b0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		load_and_rtype();
		immediates();
		shifts();
		forwarding();
		branches();
		zero_register();

		if (hung)
			$display("results still outstanding after the pipeline should have drained");
		$display("%0d tests, %0d results checked, %0d errors", test_num, checked, errors);
		if (errors == 0 && !hung)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+tests
logic/mips_pkg.sv
logic/alu.sv
logic/forwarding_unit.sv
logic/register_file.sv
logic/instr_decode.sv
logic/execute_stage.sv
logic/mem_wb_pipe.sv
logic/ex_pipe_top.sv
tests/ex_pipe_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns
TOP       := ex_pipe_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard tests/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
